// ==== vlog.f ====
+incdir+hdl
hdl/lin_pkg.sv
hdl/lin_evt_if.sv
hdl/lin_break_detect.sv
hdl/lin_inact_timer.sv
hdl/lin_bus_port.sv
hdl/lin_status_reg.sv
hdl/lin_slave_top.sv
verif/lin_slave_sva.sv
verif/tb_lin_slave.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds and runs the LIN slave testbench with Verilator from the project root.

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f vlog.f --top-module tb_lin_slave -o tb_lin_slave
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_lin_slave > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "test failed" "$LOG"; then
    exit 1
fi
exit 0

// ==== verif/tb_lin_slave.sv ====
// Lengths stay at least 10 cycles from each threshold; the receive gate is probed inside dut0.
`timescale 1ns/1ps
`default_nettype none

`include "lin_cfg.svh"

module tb_lin_slave
    import lin_pkg::*;
();

    localparam int NUM_ENTRIES = 7;
    localparam int BRK_LONG    = `LIN_BREAK_THRESH + 20;
    localparam int BRK_SHORT   = `LIN_BREAK_THRESH - 20;
    localparam int INA_LONG    = `LIN_INACT_THRESH + 10;
    localparam int INA_SHORT   = `LIN_INACT_THRESH - 20;

    // One stimulus step: settings, bus phases, expected results.
    typedef struct packed {
        logic start;
        logic txd_dis;
        logic rxd_dis;
        sts_t int_mask;
        int   low_cyc;
        int   high_cyc;
        sts_t exp_sts;
        logic exp_gate;
        logic exp_int;
    } entry_t;

    logic clk_fin;
    logic rst;
    logic start;
    logic txd_dis;
    logic rxd_dis;
    logic rxd;
    logic txd;
    logic status_rd;
    logic rxd_out;
    logic txd_out;
    logic interrupt;
    sts_t int_mask;
    sts_t status;

    entry_t      tbl [NUM_ENTRIES];
    logic [31:0] rng_state;
    int          err_val;
    int          err_to;
    int          err_sva;
    // Receive gate as the rules predict it at the start of an entry.
    logic        gate_model;

    lin_slave_top dut0 (
        .clk_fin   (clk_fin),
        .rst       (rst),
        .start     (start),
        .txd_dis   (txd_dis),
        .rxd_dis   (rxd_dis),
        .rxd       (rxd),
        .txd       (txd),
        .status_rd (status_rd),
        .int_mask  (int_mask),
        .rxd_out   (rxd_out),
        .txd_out   (txd_out),
        .status    (status),
        .interrupt (interrupt)
    );

    // 40 ns clock.
    always #20 clk_fin = ~clk_fin;

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // Status word built from the bit positions.
    function automatic sts_t sts_bits(input logic brk, input logic edg, input logic ina);
        sts_t s;
        s                 = '0;
        s[`LIN_STS_BREAK] = brk;
        s[`LIN_STS_EDGE]  = edg;
        s[`LIN_STS_INACT] = ina;
        return s;
    endfunction

    task automatic check_sts(input sts_t got, input sts_t exp, input string what);
        if (got !== exp)
        begin
            err_val++;
            $display("ERROR at %0d ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp)
        begin
            err_val++;
            $display("ERROR at %0d ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // One cycle.
    // Outputs due at the coming edge follow the inputs as they stand now.
    task automatic drive_cycle(input logic rxd_v);
        logic [31:0] rnd;
        logic        exp_txd;
        logic        exp_rxd;
        exp_txd = txd_dis ? 1'b0 : txd;
        exp_rxd = gate_model ? rxd : 1'b1;
        @(posedge clk_fin);
        #5;
        check_bit(txd_out, exp_txd, "txd_out");
        check_bit(rxd_out, exp_rxd, "rxd_out");
        rnd = next_rand();
        rxd = rxd_v;
        txd = rnd[16];
    endtask

    task automatic wait_reset_values();
        logic ok;
        int   n;
        ok = 1'b0;
        n  = 0;
        while (!ok && n < 10)
        begin
            @(posedge clk_fin);
            #5;
            ok = (rxd_out === 1'b1) && (txd_out === 1'b1) && (status === '0);
            ok = ok && (interrupt === 1'b0);
            n++;
        end
        if (!ok)
        begin
            err_to++;
            $display("Timeout: outputs never reached their reset values after reset.");
        end
    endtask

    task automatic run_entry(input entry_t e, input int idx);
        logic [31:0] rnd;
        int          low_n;
        int          high_n;
        rnd      = next_rand();
        low_n    = e.low_cyc + int'(rnd[2:0]);
        high_n   = e.high_cyc + int'(rnd[4:3]);
        start    = e.start;
        txd_dis  = e.txd_dis;
        int_mask = e.int_mask;
        for (int i = 0; i < low_n; i++)
            drive_cycle(1'b0);
        for (int i = 0; i < high_n; i++)
            drive_cycle(1'b1);
        // One more edge so the last high bit is taken in.
        drive_cycle(1'b1);
        check_sts(status, e.exp_sts, $sformatf("entry %0d status", idx));
        check_bit(interrupt, e.exp_int, $sformatf("entry %0d interrupt", idx));
        check_bit(dut0.u_port.rx_gate, e.exp_gate, $sformatf("entry %0d gate", idx));
        // Read clears the sticky bits.
        status_rd = 1'b1;
        rxd_dis   = e.rxd_dis;
        drive_cycle(1'b1);
        status_rd = 1'b0;
        rxd_dis   = 1'b0;
        drive_cycle(1'b1);
        check_sts(status, '0, $sformatf("entry %0d status after read", idx));
        gate_model = e.exp_gate && !e.rxd_dis && e.start;
    endtask

    initial
    begin
        clk_fin    = 1'b0;
        rst        = 1'b1;
        start      = 1'b0;
        txd_dis    = 1'b0;
        rxd_dis    = 1'b0;
        rxd        = 1'b1;
        txd        = 1'b1;
        status_rd  = 1'b0;
        int_mask   = '0;
        rng_state  = 32'h7617;
        err_val    = 0;
        err_to     = 0;
        err_sva    = 0;
        gate_model = 1'b0;
        // Long break opens the gate; gate then passes rxd until rxd_dis.
        tbl[0] = '{1'b1, 1'b0, 1'b0, sts_bits(1, 0, 0), BRK_LONG, 30,
                   sts_bits(1, 1, 0), 1'b1, 1'b1};
        tbl[1] = '{1'b1, 1'b1, 1'b1, sts_bits(1, 0, 0), 30, 30,
                   sts_bits(0, 1, 0), 1'b1, 1'b0};
        // Short low phase is no break.
        tbl[2] = '{1'b1, 1'b0, 1'b0, sts_bits(1, 0, 0), BRK_SHORT, 30,
                   sts_bits(0, 1, 0), 1'b0, 1'b0};
        tbl[3] = '{1'b1, 1'b0, 1'b0, sts_bits(0, 0, 1), 20, INA_LONG,
                   sts_bits(0, 1, 1), 1'b0, 1'b1};
        // High run short of the threshold, broken by the next low phase.
        tbl[4] = '{1'b1, 1'b1, 1'b0, sts_bits(0, 0, 1), 20, INA_SHORT,
                   sts_bits(0, 1, 0), 1'b0, 1'b0};
        tbl[5] = '{1'b1, 1'b0, 1'b0, sts_bits(0, 1, 0), 20, 20,
                   sts_bits(0, 1, 0), 1'b0, 1'b1};
        // With the block stopped only the edge bit still works.
        tbl[6] = '{1'b0, 1'b0, 1'b0, sts_bits(1, 0, 0), BRK_LONG, 30,
                   sts_bits(0, 1, 0), 1'b0, 1'b0};
        repeat (2) @(posedge clk_fin);
        #5;
        rst = 1'b0;
        wait_reset_values();
        for (int i = 0; i < NUM_ENTRIES; i++)
            run_entry(tbl[i], i);
        err_sva = dut0.sva0.fail_cnt;
        $display("Checks finished: %0d value errors, %0d timeouts, %0d assertion failures.",
                 err_val, err_to, err_sva);
        if (err_val == 0 && err_to == 0 && err_sva == 0)
        begin
            $display("test passed");
        end
        else
        begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/lin_slave_sva.sv ====
// Bound into lin_slave_top; the break strobe and receive gate are read from inside the DUT.
`timescale 1ns/1ps
`default_nettype none

module lin_slave_sva
    import lin_pkg::*;
(
    input wire logic clk_fin,
    input wire logic rst,
    input wire logic break_pulse,
    input wire logic rx_gate,
    input wire logic rxd_out,
    input wire logic txd_out,
    input wire sts_t status,
    input wire sts_t int_mask,
    input wire logic interrupt
);

    // Number of assertion failures so far.
    int fail_cnt = 0;

    // One break strobe per low phase.
    a_brk_single: assert property (@(posedge clk_fin) disable iff (rst)
        break_pulse |=> !break_pulse)
    else
    begin
        fail_cnt++;
        $error("break_pulse high on two cycles in a row");
    end

    // Interrupt only follows a masked status bit.
    a_int_cause: assert property (@(posedge clk_fin) disable iff (rst)
        interrupt |-> $past(|(status & int_mask)))
    else
    begin
        fail_cnt++;
        $error("interrupt without a masked status bit");
    end

    // Closed gate keeps the UART line recessive.
    a_gate_idle: assert property (@(posedge clk_fin) disable iff (rst)
        !rx_gate |=> rxd_out)
    else
    begin
        fail_cnt++;
        $error("rxd_out low while the receive gate was closed");
    end

    a_reset_vals: assert property (@(posedge clk_fin)
        rst |=> (rxd_out && txd_out && (status == '0) && !interrupt))
    else
    begin
        fail_cnt++;
        $error("outputs not at reset values after rst");
    end

endmodule

bind lin_slave_top lin_slave_sva sva0 (
    .clk_fin     (clk_fin),
    .rst         (rst),
    .break_pulse (evt_bus.break_pulse),
    .rx_gate     (u_port.rx_gate),
    .rxd_out     (rxd_out),
    .txd_out     (txd_out),
    .status      (status),
    .int_mask    (int_mask),
    .interrupt   (interrupt)
);

`default_nettype wire

// ==== hdl/lin_slave_top.sv ====
// Single clock at 16x baud; rxd is taken as already synchronous to clk_fin.
`timescale 1ns/1ps
`default_nettype none

module lin_slave_top
    import lin_pkg::*;
(
    input  wire logic clk_fin,
    input  wire logic rst,
    input  wire logic start,
    input  wire logic txd_dis,
    input  wire logic rxd_dis,
    input  wire logic rxd,
    input  wire logic txd,
    input  wire logic status_rd,
    input  wire sts_t int_mask,
    output logic      rxd_out,
    output logic      txd_out,
    output sts_t      status,
    output logic      interrupt
);

    // Event bundle shared by the detectors, bus port and status register.
    lin_evt_if evt_bus (
        .clk_fin (clk_fin)
    );

    // Break and delimiter detection.
    lin_break_detect u_break (
        .clk_fin (clk_fin),
        .rst     (rst),
        .start   (start),
        .rxd     (rxd),
        .evt     (evt_bus.brk_src)
    );

    // Bus inactivity timer.
    lin_inact_timer u_inact (
        .clk_fin (clk_fin),
        .rst     (rst),
        .start   (start),
        .rxd     (rxd),
        .evt     (evt_bus.inact_src)
    );

    // Line gating and edge detection.
    lin_bus_port u_port (
        .clk_fin (clk_fin),
        .rst     (rst),
        .start   (start),
        .txd_dis (txd_dis),
        .rxd_dis (rxd_dis),
        .rxd     (rxd),
        .txd     (txd),
        .evt     (evt_bus.port_mp),
        .rxd_out (rxd_out),
        .txd_out (txd_out)
    );

    // Sticky status and interrupt.
    lin_status_reg u_sts (
        .clk_fin   (clk_fin),
        .rst       (rst),
        .status_rd (status_rd),
        .int_mask  (int_mask),
        .evt       (evt_bus.sts_sink),
        .status    (status),
        .interrupt (interrupt)
    );

endmodule

`default_nettype wire

// ==== hdl/lin_status_reg.sv ====
// Clear on read is a single status_rd strobe; an event in the same cycle survives the clear.
`timescale 1ns/1ps
`default_nettype none

`include "lin_cfg.svh"

module lin_status_reg
    import lin_pkg::*;
(
    input  wire logic   clk_fin,
    input  wire logic   rst,
    input  wire logic   status_rd,
    input  wire sts_t   int_mask,
    lin_evt_if.sts_sink evt,
    output sts_t        status,
    output logic        interrupt
);

    sts_t evt_vec;

    // Gather the event strobes into status bit order.
    always_comb
    begin
        evt_vec                 = '0;
        evt_vec[`LIN_STS_BREAK] = evt.break_pulse;
        evt_vec[`LIN_STS_EDGE]  = evt.rxd_edge;
        evt_vec[`LIN_STS_INACT] = evt.inact;
    end

    // Sticky bits.
    // A read wipes old events, new ones are or-ed in after the wipe.
    always_ff @(posedge clk_fin)
    begin
        if (rst)
        begin
            status <= '0;
        end
        else
        begin
            status <= (status_rd ? '0 : status) | evt_vec;
        end
    end

    // Interrupt follows the masked status one cycle later.
    always_ff @(posedge clk_fin)
    begin
        if (rst)
        begin
            interrupt <= 1'b0;
        end
        else
        begin
            interrupt <= |(status & int_mask);
        end
    end

endmodule

`default_nettype wire

// ==== hdl/lin_bus_port.sv ====
// No synchronizer on rxd; rxd_out and txd_out lag their sources by one clk_fin cycle.
`timescale 1ns/1ps
`default_nettype none

module lin_bus_port (
    input  wire logic  clk_fin,
    input  wire logic  rst,
    input  wire logic  start,
    input  wire logic  txd_dis,
    input  wire logic  rxd_dis,
    input  wire logic  rxd,
    input  wire logic  txd,
    lin_evt_if.port_mp evt,
    output logic       rxd_out,
    output logic       txd_out
);

    logic rx_gate;
    logic rxd_q;

    // Edge strobe, high in the cycle rxd differs from its last sample.
    assign evt.rxd_edge = rxd ^ rxd_q;

    // Previous rxd sample.
    // Starts recessive so an idle bus gives no edge after reset.
    always_ff @(posedge clk_fin)
    begin
        if (rst)
        begin
            rxd_q <= 1'b1;
        end
        else
        begin
            rxd_q <= rxd;
        end
    end

    // Receive gate.
    // Opens on the delimiter; software or a stop closes it, opening wins.
    always_ff @(posedge clk_fin)
    begin
        if (rst || !start)
        begin
            rx_gate <= 1'b0;
        end
        else if (evt.delim)
        begin
            rx_gate <= 1'b1;
        end
        else if (rxd_dis)
        begin
            rx_gate <= 1'b0;
        end
    end

    // Registered line outputs, both recessive out of reset.
    always_ff @(posedge clk_fin)
    begin
        if (rst)
        begin
            rxd_out <= 1'b1;
            txd_out <= 1'b1;
        end
        else
        begin
            // UART sees an idle line until the gate opens.
            rxd_out <= rx_gate ? rxd : 1'b1;
            // Forced dominant when transmit is disabled.
            txd_out <= txd_dis ? 1'b0 : txd;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/lin_inact_timer.sv ====
// rxd must be synchronous to clk_fin; a steady high bus re-signals about every threshold + 2 cycles.
`timescale 1ns/1ps
`default_nettype none

`include "lin_cfg.svh"

module lin_inact_timer
    import lin_pkg::*;
(
    input  wire logic    clk_fin,
    input  wire logic    rst,
    input  wire logic    start,
    input  wire logic    rxd,
    lin_evt_if.inact_src evt
);

    inact_state_t state;
    inact_cnt_t   high_cnt;
    logic         cnt_hit;

    assign cnt_hit = (high_cnt == inact_cnt_t'(`LIN_INACT_THRESH));

    // Inactivity strobe lasts exactly the one detect cycle.
    assign evt.inact = (state == INA_DETECT);

    // State machine.
    // Any low bit restarts the measurement.
    always_ff @(posedge clk_fin)
    begin
        if (rst || !start)
        begin
            state <= INA_IDLE;
        end
        else
        begin
            case (state)
                INA_IDLE:
                begin
                    if (rxd)
                    begin
                        state <= INA_COUNT;
                    end
                end
                INA_COUNT:
                begin
                    if (!rxd)
                    begin
                        state <= INA_IDLE;
                    end
                    else if (cnt_hit)
                    begin
                        state <= INA_DETECT;
                    end
                end
                default:
                begin
                    // Detect lasts one cycle.
                    state <= INA_IDLE;
                end
            endcase
        end
    end

    // High-time counter.
    // Counts every high cycle, restarts after a detect or on a low bit.
    always_ff @(posedge clk_fin)
    begin
        if (rst || !start || !rxd || (state == INA_DETECT))
        begin
            high_cnt <= '0;
        end
        else
        begin
            high_cnt <= high_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/lin_break_detect.sv ====
// rxd must already be synchronous to clk_fin; the break is reported once per low phase.
`timescale 1ns/1ps
`default_nettype none

`include "lin_cfg.svh"

module lin_break_detect
    import lin_pkg::*;
(
    input  wire logic   clk_fin,
    input  wire logic   rst,
    input  wire logic   start,
    input  wire logic   rxd,
    lin_evt_if.brk_src  evt
);

    break_state_t state;
    break_state_t state_nxt;
    break_cnt_t   low_cnt;
    logic         brk_flag;
    logic         brk_hit;

    // Threshold reached while the bus is still low.
    assign brk_hit = (state == BRK_LOW) && (low_cnt == break_cnt_t'(`LIN_BREAK_THRESH));

    assign evt.break_pulse = brk_hit;
    // Delimiter level comes straight from the state, so it is already gated by start.
    assign evt.delim = (state == BRK_DELIM);

    // Next state.
    always_comb
    begin
        state_nxt = state;
        case (state)
            BRK_IDLE:
            begin
                // Falling bus starts a candidate break.
                if (!rxd)
                begin
                    state_nxt = BRK_LOW;
                end
            end
            BRK_LOW:
            begin
                // A short low phase is just data, a long one is a break.
                if (rxd)
                begin
                    state_nxt = brk_flag ? BRK_DELIM : BRK_IDLE;
                end
            end
            BRK_DELIM:
            begin
                // Delimiter ends at the start bit of the sync byte.
                if (!rxd)
                begin
                    state_nxt = BRK_IDLE;
                end
            end
            default:
            begin
                state_nxt = BRK_IDLE;
            end
        endcase
    end

    // State register, held idle while the block is stopped.
    always_ff @(posedge clk_fin)
    begin
        if (rst || !start)
        begin
            state <= BRK_IDLE;
        end
        else
        begin
            state <= state_nxt;
        end
    end

    // Low-time counter.
    // Runs only in BRK_LOW and parks one past the threshold.
    always_ff @(posedge clk_fin)
    begin
        if (rst || !start || (state != BRK_LOW))
        begin
            low_cnt <= '0;
        end
        else if (low_cnt <= break_cnt_t'(`LIN_BREAK_THRESH))
        begin
            low_cnt <= low_cnt + 1'b1;
        end
    end

    // Break flag.
    // Set on the threshold hit, dropped once the delimiter is entered.
    always_ff @(posedge clk_fin)
    begin
        if (rst || !start)
        begin
            brk_flag <= 1'b0;
        end
        else if (brk_hit)
        begin
            brk_flag <= 1'b1;
        end
        else if (state == BRK_DELIM)
        begin
            brk_flag <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/lin_evt_if.sv ====
// Event strobes are single cycle and unacknowledged; a sink must sample every cycle.
`timescale 1ns/1ps
`default_nettype none

interface lin_evt_if (
    input wire logic clk_fin
);

    // One-cycle strobe when the low phase reaches the break threshold.
    logic break_pulse;
    // High while the break detector sits in the delimiter state.
    logic delim;
    // Combinational strobe on any rxd transition.
    logic rxd_edge;
    // One-cycle strobe when the bus has been high long enough.
    logic inact;

    // Break detector side.
    modport brk_src (
        output break_pulse,
        output delim
    );

    // Inactivity timer side.
    modport inact_src (
        output inact
    );

    // Bus port produces the edge strobe and follows the delimiter.
    modport port_mp (
        output rxd_edge,
        input  delim
    );

    // Status register collects the three events.
    modport sts_sink (
        input break_pulse,
        input rxd_edge,
        input inact
    );

endinterface

`default_nettype wire

// ==== hdl/lin_pkg.sv ====
// Types only; widths follow lin_cfg.svh, so the header must be on the include path.
`default_nettype none

package lin_pkg;

    `include "lin_cfg.svh"

    // Break and delimiter tracking states.
    typedef enum logic [1:0] {
        BRK_IDLE  = 2'd0,
        BRK_LOW   = 2'd1,
        BRK_DELIM = 2'd2
    } break_state_t;

    // Bus inactivity timer states.
    typedef enum logic [1:0] {
        INA_IDLE   = 2'd0,
        INA_COUNT  = 2'd1,
        INA_DETECT = 2'd2
    } inact_state_t;

    // Counter words.
    typedef logic [`LIN_BREAK_CNT_W-1:0] break_cnt_t;
    typedef logic [`LIN_INACT_CNT_W-1:0] inact_cnt_t;

    // Status word, indexed by the LIN_STS_* positions.
    typedef logic [`LIN_STS_W-1:0] sts_t;

endpackage

`default_nettype wire

// ==== hdl/lin_cfg.svh ====
// Thresholds must fit their counter widths with one count of headroom; the inactivity value is sized for simulation.
`ifndef LIN_CFG_SVH
`define LIN_CFG_SVH

// Width of the break low-time counter.
`define LIN_BREAK_CNT_W 8

// Low cycles at 16x baud that qualify as a break.
// Must stay below 2**LIN_BREAK_CNT_W - 1 so the counter can saturate past it.
`define LIN_BREAK_THRESH 100

// Width of the bus inactivity counter.
`define LIN_INACT_CNT_W 16

// High cycles that signal bus inactivity.
// Kept small for simulation. A real bus needs several seconds' worth.
`define LIN_INACT_THRESH 400

// Number of sticky status bits.
`define LIN_STS_W 3

// Status bit positions.
`define LIN_STS_BREAK 0
`define LIN_STS_EDGE 1
`define LIN_STS_INACT 2

`endif
